// File: msdapPkg.sv
package msdapPkg;

	//////////////////////////////////////////////////
	// Word and accumulator widths
	//////////////////////////////////////////////////

	// Serial input word, shared by Rj, coefficient and sample loads
	localparam int wordWidth = 16;

	// Accumulator and serial result width
	localparam int accWidth = 40;

	//////////////////////////////////////////////////
	// Memory depths and address widths
	//////////////////////////////////////////////////

	// Number of segments, one Rj word each
	localparam int rjCount = 16;
	localparam int rjAddrWidth = 4;

	// Coefficient list shared by all segments
	localparam int coefCount = 512;
	localparam int coefAddrWidth = 9;

	// Sample history, deep enough for the largest tap delay
	localparam int historyDepth = 256;
	localparam int historyAddrWidth = 8;

	//////////////////////////////////////////////////
	// Coefficient word layout
	//////////////////////////////////////////////////

	// Low bits hold the tap delay
	localparam int delayWidth = 8;

	// Set means the tap is subtracted
	localparam int signBit = 8;

	//////////////////////////////////////////////////
	// State encodings
	//////////////////////////////////////////////////

	// Load phases of the input side
	typedef enum logic [1:0]
	{
		phaseIdle,
		phaseRj,
		phaseCoef,
		phaseRun
	} loadPhase;

	// Filter sequencer, one pass per sample
	typedef enum logic [2:0]
	{
		seqIdle,
		seqReadRj,
		seqTap,
		seqShift,
		seqDone
	} seqState;

endpackage

// File: frameDecoder.sv
`timescale 1ns/1ps

module frameDecoder
(
	input logic sClk,
	input logic reset,
	input logic start,
	input logic frame,
	input logic inputL,
	input logic inputR,
	output logic inReady,
	output logic [msdapPkg::wordWidth-1:0] wordL,
	output logic [msdapPkg::wordWidth-1:0] wordR,
	output logic [msdapPkg::coefAddrWidth-1:0] writeAddr,
	output logic rjWrite,
	output logic coefWrite,
	output logic sampleWrite,
	output logic clearHistory
);

	import msdapPkg::*;

	loadPhase phase;
	logic receiving;
	logic [3:0] bitCount;
	logic acceptFrame;
	logic wordDone;
	logic [wordWidth-1:0] shiftL;
	logic [wordWidth-1:0] shiftR;
	logic [coefAddrWidth-1:0] wordCount;

	//////////////////////////////////////////////////
	// Bit assembly
	//////////////////////////////////////////////////

	// Frames before the first start carry nothing useful
	assign acceptFrame = frame && (phase != phaseIdle) && !start;

	// Bit 15 is on the line while the counter reads 15
	assign wordDone = receiving && (bitCount == 4'd15);

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
		begin
			receiving <= 1'b0;
			bitCount <= 4'd0;
		end
		else if (start)
		begin
			receiving <= 1'b0;
			bitCount <= 4'd0;
		end
		else if (acceptFrame)
		begin
			receiving <= 1'b1;
			bitCount <= 4'd1;
		end
		else if (receiving)
		begin
			bitCount <= bitCount + 4'd1;
			if (bitCount == 4'd15)
				receiving <= 1'b0;
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge sClk)
	begin
		if (acceptFrame || receiving)
		begin
			shiftL <= {inputL, shiftL[wordWidth-1:1]};
			shiftR <= {inputR, shiftR[wordWidth-1:1]};
		end
	end

	assign wordL = shiftL;
	assign wordR = shiftR;

	//////////////////////////////////////////////////
	// Write strobes
	//////////////////////////////////////////////////

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
		begin
			rjWrite <= 1'b0;
			coefWrite <= 1'b0;
			sampleWrite <= 1'b0;
		end
		else
		begin
			rjWrite <= wordDone && !start && (phase == phaseRj);
			coefWrite <= wordDone && !start && (phase == phaseCoef);
			sampleWrite <= wordDone && !start && (phase == phaseRun);
		end
	end

	// Address of the word being written, stepped once its strobe is seen
	assign writeAddr = wordCount;

	//////////////////////////////////////////////////
	// Load phase control
	//////////////////////////////////////////////////

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
		begin
			phase <= phaseIdle;
			wordCount <= '0;
			inReady <= 1'b0;
		end
		else if (start)
		begin
			phase <= phaseRj;
			wordCount <= '0;
			inReady <= 1'b1;
		end
		else
		begin
			case (phase)
				phaseRj:
				begin
					if (rjWrite && wordCount == coefAddrWidth'(rjCount - 1))
					begin
						phase <= phaseCoef;
						wordCount <= '0;
					end
					else if (rjWrite)
						wordCount <= wordCount + 1'b1;
				end
				phaseCoef:
				begin
					if (coefWrite && wordCount == coefAddrWidth'(coefCount - 1))
					begin
						phase <= phaseRun;
						wordCount <= '0;
					end
					else if (coefWrite)
						wordCount <= wordCount + 1'b1;
				end
				phaseRun:
				begin
					// History address wraps within 256 entries
					if (sampleWrite)
						wordCount <= {{(coefAddrWidth - historyAddrWidth){1'b0}},
							wordCount[historyAddrWidth-1:0] + 1'b1};
				end
				default:
					wordCount <= '0;
			endcase
		end
	end

	// Start also restarts the execute side
	assign clearHistory = start;

	// A new frame may only begin once all 16 bits of the last word are in
	assert property (@(posedge sClk) disable iff (!reset) receiving |-> !frame);

endmodule

// File: filterExecute.sv
`timescale 1ns/1ps

module filterExecute
(
	input logic sClk,
	input logic reset,
	input logic clearHistory,
	input logic rjWrite,
	input logic coefWrite,
	input logic sampleWrite,
	input logic [msdapPkg::wordWidth-1:0] wordL,
	input logic [msdapPkg::wordWidth-1:0] wordR,
	input logic [msdapPkg::coefAddrWidth-1:0] writeAddr,
	output logic [msdapPkg::accWidth-1:0] yL,
	output logic [msdapPkg::accWidth-1:0] yR,
	output logic yValid
);

	import msdapPkg::*;

	// Index 0 is the left channel, index 1 the right
	logic [wordWidth-1:0] wordIn [2];
	logic [wordWidth-1:0] rjMem [2][rjCount];
	logic [wordWidth-1:0] coefMem [2][coefCount];
	logic [wordWidth-1:0] historyMem [2][historyDepth];

	seqState state;
	logic [rjAddrWidth-1:0] segIndex;
	logic [historyAddrWidth-1:0] newestAddr;
	logic [historyAddrWidth:0] sampleCount;
	logic [wordWidth-1:0] remaining [2];
	logic [coefAddrWidth:0] coefPtr [2];
	logic [accWidth-1:0] acc [2];
	logic [wordWidth-1:0] coefWord [2];
	logic [delayWidth-1:0] delay [2];
	logic [wordWidth-1:0] tapSample [2];
	logic [accWidth-1:0] tapTerm [2];
	logic segmentDone;

	assign wordIn[0] = wordL;
	assign wordIn[1] = wordR;

	//////////////////////////////////////////////////
	// Memories
	//////////////////////////////////////////////////

	always_ff @(posedge sClk)
	begin
		for (int ch = 0; ch < 2; ch++)
		begin
			if (rjWrite)
				rjMem[ch][writeAddr[rjAddrWidth-1:0]] <= wordIn[ch];
			if (coefWrite)
				coefMem[ch][writeAddr] <= wordIn[ch];
			if (sampleWrite)
				historyMem[ch][writeAddr[historyAddrWidth-1:0]] <= wordIn[ch];
		end
		// Position of x[n] for the pass that follows
		if (sampleWrite)
			newestAddr <= writeAddr[historyAddrWidth-1:0];
	end

	//////////////////////////////////////////////////
	// Tap datapath
	//////////////////////////////////////////////////

	always_comb
	begin
		for (int ch = 0; ch < 2; ch++)
		begin
			coefWord[ch] = coefMem[ch][coefPtr[ch][coefAddrWidth-1:0]];
			delay[ch] = coefWord[ch][delayWidth-1:0];
			// Delay reaching back before sample 0 gives a zero tap
			if ({1'b0, delay[ch]} >= sampleCount)
				tapSample[ch] = '0;
			else
				tapSample[ch] = historyMem[ch][newestAddr - delay[ch]];
			// Sample sits at bits 31..16, sign extended above
			tapTerm[ch] = {{(accWidth - 2 * wordWidth){tapSample[ch][wordWidth-1]}},
				tapSample[ch], {wordWidth{1'b0}}};
		end
	end

	// Segment ends once the longer of the two channels runs out
	assign segmentDone = (remaining[0] == '0) && (remaining[1] == '0);

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
		begin
			state <= seqIdle;
			segIndex <= '0;
			sampleCount <= '0;
			for (int ch = 0; ch < 2; ch++)
			begin
				remaining[ch] <= '0;
				coefPtr[ch] <= '0;
				acc[ch] <= '0;
			end
		end
		else if (clearHistory)
		begin
			state <= seqIdle;
			sampleCount <= '0;
		end
		else
		begin
			// Saturates once the history is full
			if (sampleWrite && sampleCount != historyDepth)
				sampleCount <= sampleCount + 1'b1;
			case (state)
				seqIdle:
				begin
					if (sampleWrite)
					begin
						segIndex <= '0;
						for (int ch = 0; ch < 2; ch++)
						begin
							coefPtr[ch] <= '0;
							acc[ch] <= '0;
						end
						state <= seqReadRj;
					end
				end
				seqReadRj:
				begin
					for (int ch = 0; ch < 2; ch++)
						remaining[ch] <= rjMem[ch][segIndex];
					state <= seqTap;
				end
				seqTap:
				begin
					if (segmentDone)
						state <= seqShift;
					for (int ch = 0; ch < 2; ch++)
					begin
						if (remaining[ch] != '0)
						begin
							if (coefWord[ch][signBit])
								acc[ch] <= acc[ch] - tapTerm[ch];
							else
								acc[ch] <= acc[ch] + tapTerm[ch];
							coefPtr[ch] <= coefPtr[ch] + 1'b1;
							remaining[ch] <= remaining[ch] - 1'b1;
						end
					end
				end
				seqShift:
				begin
					// Arithmetic shift right by one after every segment
					for (int ch = 0; ch < 2; ch++)
						acc[ch] <= {acc[ch][accWidth-1], acc[ch][accWidth-1:1]};
					if (segIndex == rjAddrWidth'(rjCount - 1))
						state <= seqDone;
					else
					begin
						segIndex <= segIndex + 1'b1;
						state <= seqReadRj;
					end
				end
				default:
					state <= seqIdle;
			endcase
		end
	end

	// Accumulators hold the result until the next sample arrives
	assign yL = acc[0];
	assign yR = acc[1];
	assign yValid = (state == seqDone);

	// Input pacing must leave time for the whole pass
	assert property (@(posedge sClk) disable iff (!reset)
		sampleWrite |-> state == seqIdle);

	// Sum of all Rj must stay within the coefficient list
	assert property (@(posedge sClk) disable iff (!reset)
		state == seqTap |-> (remaining[0] == '0 || coefPtr[0] < coefCount) &&
			(remaining[1] == '0 || coefPtr[1] < coefCount));

endmodule

// File: resultSerializer.sv
`timescale 1ns/1ps

module resultSerializer
(
	input logic sClk,
	input logic reset,
	input logic yValid,
	input logic [msdapPkg::accWidth-1:0] yL,
	input logic [msdapPkg::accWidth-1:0] yR,
	output logic outReady,
	output logic outputL,
	output logic outputR
);

	import msdapPkg::*;

	logic [accWidth-1:0] shiftL;
	logic [accWidth-1:0] shiftR;
	logic [accWidth-1:0] holdL;
	logic [accWidth-1:0] holdR;
	logic holdValid;
	logic [5:0] bitCount;
	logic lastBit;
	logic freeSlot;
	logic takeHold;
	logic takeNew;

	// Shifter can accept a word now or right after the current last bit
	assign lastBit = outReady && (bitCount == 6'(accWidth - 1));
	assign freeSlot = !outReady || lastBit;
	assign takeHold = freeSlot && holdValid;
	assign takeNew = freeSlot && !holdValid && yValid;

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
		begin
			outReady <= 1'b0;
			bitCount <= '0;
			holdValid <= 1'b0;
		end
		else
		begin
			if (takeHold || takeNew)
			begin
				outReady <= 1'b1;
				bitCount <= '0;
			end
			else if (freeSlot)
				outReady <= 1'b0;
			else
				bitCount <= bitCount + 1'b1;
			// Hold fills when the new result cannot go straight in
			holdValid <= (holdValid && !takeHold) || (yValid && !takeNew);
		end
	end

	//////////////////////////////////////////////////
	// Shift and hold registers
	//////////////////////////////////////////////////

	always_ff @(posedge sClk)
	begin
		if (takeHold)
		begin
			shiftL <= holdL;
			shiftR <= holdR;
		end
		else if (takeNew)
		begin
			shiftL <= yL;
			shiftR <= yR;
		end
		else
		begin
			shiftL <= shiftL >> 1;
			shiftR <= shiftR >> 1;
		end
		if (yValid && !takeNew)
		begin
			holdL <= yL;
			holdR <= yR;
		end
	end

	// LSB first, low while idle
	assign outputL = outReady && shiftL[0];
	assign outputR = outReady && shiftR[0];

	// Only one result may wait behind the word on the lines
	assert property (@(posedge sClk) disable iff (!reset)
		yValid && holdValid |-> freeSlot);

endmodule

// File: msdap.sv
`timescale 1ns/1ps

module msdap
(
	input logic sClk,
	input logic reset,
	input logic start,
	input logic frame,
	input logic inputL,
	input logic inputR,
	output logic inReady,
	output logic outReady,
	output logic outputL,
	output logic outputR
);

	import msdapPkg::*;

	// Decoder to execute
	logic [wordWidth-1:0] wordL;
	logic [wordWidth-1:0] wordR;
	logic [coefAddrWidth-1:0] writeAddr;
	logic rjWrite;
	logic coefWrite;
	logic sampleWrite;
	logic clearHistory;

	// Execute to serializer
	logic [accWidth-1:0] yL;
	logic [accWidth-1:0] yR;
	logic yValid;

	frameDecoder decoder
	(
		.sClk(sClk),
		.reset(reset),
		.start(start),
		.frame(frame),
		.inputL(inputL),
		.inputR(inputR),
		.inReady(inReady),
		.wordL(wordL),
		.wordR(wordR),
		.writeAddr(writeAddr),
		.rjWrite(rjWrite),
		.coefWrite(coefWrite),
		.sampleWrite(sampleWrite),
		.clearHistory(clearHistory)
	);

	filterExecute execute
	(
		.sClk(sClk),
		.reset(reset),
		.clearHistory(clearHistory),
		.rjWrite(rjWrite),
		.coefWrite(coefWrite),
		.sampleWrite(sampleWrite),
		.wordL(wordL),
		.wordR(wordR),
		.writeAddr(writeAddr),
		.yL(yL),
		.yR(yR),
		.yValid(yValid)
	);

	resultSerializer result
	(
		.sClk(sClk),
		.reset(reset),
		.yValid(yValid),
		.yL(yL),
		.yR(yR),
		.outReady(outReady),
		.outputL(outputL),
		.outputR(outputR)
	);

endmodule

// File: msdapTbModel.svh
`ifndef msdapTbModelSvh
`define msdapTbModelSvh

//////////////////////////////////////////////////
// Random source and reference filter
//////////////////////////////////////////////////

logic [31:0] lfsrState;

// Model memories, index 0 is the left channel
logic [wordWidth-1:0] modelRj [2][rjCount];
logic [wordWidth-1:0] modelCoef [2][coefCount];
logic [wordWidth-1:0] modelHist [2][sampleTotal];

// Fibonacci LFSR, one step per returned bit
function automatic logic [31:0] randomBits(input int count);
	logic [31:0] value;
	logic feedback;
	value = '0;
	for (int i = 0; i < count; i++)
	begin
		// Taps 32, 22, 2 and 1
		feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], feedback};
		value = {value[30:0], feedback};
	end
	return value;
endfunction

// Segmented shift-and-add result for sample n of one channel
function automatic logic [accWidth-1:0] filterOutput(input int ch, input int n);
	logic [accWidth-1:0] u;
	logic [accWidth-1:0] tap;
	logic [wordWidth-1:0] coef;
	logic [wordWidth-1:0] x;
	int k;
	int d;
	u = '0;
	k = 0;
	for (int j = 0; j < rjCount; j++)
	begin
		for (int i = 0; i < int'(modelRj[ch][j]); i++)
		begin
			coef = modelCoef[ch][k];
			k++;
			d = int'(coef[delayWidth-1:0]);
			// Nothing was sampled before sample 0
			if (d > n)
				x = '0;
			else
				x = modelHist[ch][n - d];
			tap = {{(accWidth - wordWidth){x[wordWidth-1]}}, x} << wordWidth;
			if (coef[signBit])
				u = u - tap;
			else
				u = u + tap;
		end
		u = $signed(u) >>> 1;
	end
	return u;
endfunction

`endif

// File: msdapTb.sv
`timescale 1ns/1ps

module msdapTb;

	import msdapPkg::*;

	localparam int sampleTotal = 300;
	localparam logic [31:0] lfsrSeed = 32'h5601;
	localparam int resultTimeout = 2000;
	localparam int drainTimeout = 200;

	logic sClk;
	logic reset;
	logic start;
	logic frame;
	logic inputL;
	logic inputR;
	logic inReady;
	logic outReady;
	logic outputL;
	logic outputR;

	int valueErrors = 0;
	int otherErrors = 0;
	int resultCount = 0;
	int checkedCount = 0;
	int expectedCount = 0;
	bit timedOut = 1'b0;
	logic [accWidth-1:0] expectL [$];
	logic [accWidth-1:0] expectR [$];

	`include "msdapTbModel.svh"

	msdap DUT
	(
		.sClk(sClk),
		.reset(reset),
		.start(start),
		.frame(frame),
		.inputL(inputL),
		.inputR(inputR),
		.inReady(inReady),
		.outReady(outReady),
		.outputL(outputL),
		.outputR(outputR)
	);

	initial
	begin
		sClk = 1'b0;
		forever
			#10 sClk = ~sClk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic void expectLevel(input string name, input logic got, input logic want);
		assert (got === want) else
		begin
			valueErrors++;
			$display("** Error %s: got %h, expected %h", name, got, want);
		end
	endfunction

	// One word, LSB first, frame high with bit 0
	task automatic sendWord(input logic [wordWidth-1:0] l, input logic [wordWidth-1:0] r);
		for (int i = 0; i < wordWidth; i++)
		begin
			@(negedge sClk);
			frame = (i == 0);
			inputL = l[i];
			inputR = r[i];
		end
	endtask

	task automatic pulseStart();
		@(negedge sClk);
		start = 1'b1;
		@(negedge sClk);
		start = 1'b0;
		expectLevel("inReady", inReady, 1'b1);
	endtask

	// Rising edge only, since the capture block counts on the falling edge
	task automatic awaitCount(input bit checkedOnly, input int target, input int limit);
		int cycles;
		int seen;
		cycles = 0;
		seen = checkedOnly ? checkedCount : resultCount;
		while (seen < target && cycles < limit)
		begin
			@(posedge sClk);
			cycles++;
			seen = checkedOnly ? checkedCount : resultCount;
		end
		if (seen < target)
		begin
			timedOut = 1'b1;
			otherErrors++;
			$display("Timeout after %0d cycles waiting for result %0d", limit, target);
		end
	endtask

	// Load Rj and coefficients, then stream samples one result at a time
	task automatic runPass(input bit largeDelays);
		pulseStart();
		for (int j = 0; j < rjCount; j++)
		begin
			for (int ch = 0; ch < 2; ch++)
				modelRj[ch][j] = wordWidth'(randomBits(5));
			sendWord(modelRj[0][j], modelRj[1][j]);
		end
		for (int k = 0; k < coefCount; k++)
		begin
			for (int ch = 0; ch < 2; ch++)
			begin
				modelCoef[ch][k] = wordWidth'(randomBits(9));
				// Delays of 128 and up reach before sample 0 early on
				if (largeDelays)
					modelCoef[ch][k][delayWidth-1] = 1'b1;
			end
			sendWord(modelCoef[0][k], modelCoef[1][k]);
		end
		for (int n = 0; n < sampleTotal && !timedOut; n++)
		begin
			for (int ch = 0; ch < 2; ch++)
				modelHist[ch][n] = wordWidth'(randomBits(16));
			expectL.push_back(filterOutput(0, n));
			expectR.push_back(filterOutput(1, n));
			expectedCount++;
			sendWord(modelHist[0][n], modelHist[1][n]);
			awaitCount(1'b0, expectedCount, resultTimeout);
		end
		if (!timedOut)
			awaitCount(1'b1, expectedCount, drainTimeout);
	endtask

	//////////////////////////////////////////////////
	// Output capture
	//////////////////////////////////////////////////

	initial
	begin : captureBlock
		logic [accWidth-1:0] gotL;
		logic [accWidth-1:0] gotR;
		logic [accWidth-1:0] wantL;
		logic [accWidth-1:0] wantR;
		forever
		begin
			@(negedge sClk);
			if (reset && outReady)
			begin
				resultCount++;
				for (int b = 0; b < accWidth; b++)
				begin
					if (b > 0)
						@(negedge sClk);
					assert (outReady) else
					begin
						otherErrors++;
						$display("outReady fell after %0d of %0d result bits", b, accWidth);
					end
					gotL[b] = outputL;
					gotR[b] = outputR;
				end
				assert (expectL.size() > 0) else
				begin
					otherErrors++;
					$display("A result came out with no sample pending");
				end
				if (expectL.size() > 0)
				begin
					wantL = expectL.pop_front();
					wantR = expectR.pop_front();
					assert (gotL === wantL) else
					begin
						valueErrors++;
						$display("** Error outputL: got %h, expected %h", gotL, wantL);
					end
					assert (gotR === wantR) else
					begin
						valueErrors++;
						$display("** Error outputR: got %h, expected %h", gotR, wantR);
					end
				end
				// Exactly 40 cycles per result
				@(negedge sClk);
				assert (!outReady) else
				begin
					otherErrors++;
					$display("outReady stayed high longer than %0d cycles", accWidth);
				end
				checkedCount++;
			end
		end
	end

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		reset = 1'b0;
		start = 1'b0;
		frame = 1'b0;
		inputL = 1'b0;
		inputR = 1'b0;
		lfsrState = lfsrSeed;
		repeat (3) @(negedge sClk);
		reset = 1'b1;
		@(negedge sClk);
		expectLevel("inReady", inReady, 1'b0);
		expectLevel("outReady", outReady, 1'b0);
		expectLevel("outputL", outputL, 1'b0);
		expectLevel("outputR", outputR, 1'b0);
		runPass(1'b0);
		// Second start with a fresh load and no history
		if (!timedOut)
			runPass(1'b1);
		$display("Checks finished with %0d value errors and %0d other errors",
			valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: all.f
+incdir+.
msdapPkg.sv
frameDecoder.sv
filterExecute.sv
resultSerializer.sv
msdap.sv
msdapTb.sv

// File: Makefile
TOOL = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = msdapTb
FILELIST = all.f
BUILD = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation did not complete"; exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD) $(LOG)
